//--- Bender.yml
package:
  name: scope_dac

sources:
  - verilog/scope_pkg.sv
  - verilog/dac_pkg.sv
  - verilog/sample_rate_gen.sv
  - verilog/capture_stream.sv
  - verilog/waveform_lut.sv
  - verilog/dac_output.sv
  - verilog/scope_dac_top.sv
  - target: test
    files:
      - bench/scope_dac_tb.sv

//--- bench/scope_dac_tb.sv
`timescale 1ns/1ps

module scope_dac_tb;

    import scope_pkg::*;
    import dac_pkg::*;

    logic          adc_clk;
    logic          reset;
    stream_word_t  adc_a;
    stream_word_t  adc_b;
    capture_cfg_t  capture_cfg;
    logic          start;
    stream_word_t  capture_out;
    sample_count_t capture_count;
    logic          capture_busy;
    dac_cfg_t      dac_cfg;
    lut_wr_t       lut_wr;
    logic          lut_trig;
    logic [15:0]   dac_a;
    logic [15:0]   dac_b;

    logic [31:0]   lfsr;                            // random source state
    int            error_count;                     // wrong values seen
    int            fail_count;                      // timeouts, wrong word counts
    sample_t       expect_q[$];                     // model record of valid input words
    sample_t       got_q[$];                        // words seen on capture_out
    int            got_cycle_q[$];                  // cycle index of each captured word
    dac_word_t     lut_model[256];                  // expected table contents

    scope_dac_top scope_dac_top_i (.*);

    always #20 adc_clk = ~adc_clk;                  // 40 ns period

    // fibonacci step, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};              // one step per bit
        return v;
    endfunction

    // expected offset binary code for constant selections 1..3
    function automatic logic [15:0] const_code(bit is_b, int code);
        logic [15:0] signed_val;
        case (code)
            1:       signed_val = is_b ? MINUS_QUARTER : PLUS_QUARTER;
            2:       signed_val = is_b ? PLUS_QUARTER : MINUS_QUARTER;
            default: signed_val = 16'h0000;         // mid-scale
        endcase
        return signed_val ^ 16'h8000;               // sign bit flipped
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        error_count++;
    endtask

    task automatic report_failure(string what);
        $display("%s at %0t", what, $time);
        fail_count++;
    endtask

    // one start edge, collect the window, optional random converter traffic
    task automatic run_capture(int num, bit adc_traffic);
        stream_word_t a_word;
        stream_word_t b_word;
        bit           seen_busy;
        int           cycle;
        expect_q.delete();
        got_q.delete();
        got_cycle_q.delete();
        seen_busy = 1'b0;
        for (cycle = 0; cycle < 1000; cycle++)
        begin
            @(posedge adc_clk);
            a_word = '0;
            b_word = '0;
            if (adc_traffic)
            begin
                a_word.data  = random_bits(32);
                a_word.valid = lfsr_bit();          // roughly every other cycle
                b_word.data  = random_bits(32);
                b_word.valid = lfsr_bit();
            end
            adc_a <= a_word;
            adc_b <= b_word;
            start <= 1'b1;
            if (capture_cfg.source == src_adc_a && a_word.valid)
                expect_q.push_back(a_word.data);    // eligible from the start edge on
            if (capture_cfg.source == src_adc_b && b_word.valid)
                expect_q.push_back(b_word.data);
            @(negedge adc_clk);
            if (capture_out.valid)
            begin
                got_q.push_back(capture_out.data);
                got_cycle_q.push_back(cycle);
            end
            if (capture_busy)
                seen_busy = 1'b1;
            else if (seen_busy)
                break;                              // window closed
        end
        if (cycle == 1000)
            report_failure("capture window did not open and close within 1000 cycles");
        if (got_q.size() != num)
            report_failure($sformatf("captured %0d words instead of %0d", got_q.size(), num));
        if (capture_count !== sample_count_t'(num))
            report_mismatch("capture_count", capture_count, num);
        @(posedge adc_clk);
        start <= 1'b0;
        adc_a <= '0;
        adc_b <= '0;
    endtask

    initial
    begin
        int          cps;                           // clocks_per_sample under test
        int          num;                           // words per window
        int          wait_cnt;
        logic [31:0] rnd;
        logic [15:0] a_hist[$];                     // upper halves driven on adc_a
        lfsr        = 32'h4788518d;
        error_count = 0;
        fail_count  = 0;
        adc_clk     = 1'b0;
        reset       = 1'b1;
        adc_a       = '0;
        adc_b       = '0;
        capture_cfg = '{clocks_per_sample: 24'd3, num_samples: 30'd4, source: src_count};
        start       = 1'b0;
        dac_cfg     = '{dac_a_sel: a_mid, dac_b_sel: b_mid, lut_addr_sel: addr_counter,
                        run_once: 1'b0};
        lut_wr      = '0;
        lut_trig    = 1'b0;

        @(posedge adc_clk);
        @(negedge adc_clk);
        if (capture_busy !== 1'b0)
            report_mismatch("capture_busy", capture_busy, 0);
        if (capture_out.valid !== 1'b0)
            report_mismatch("capture_out.valid", capture_out.valid, 0);
        if (capture_count !== '0)
            report_mismatch("capture_count", capture_count, 0);
        if (dac_a !== 16'h8000)
            report_mismatch("dac_a", dac_a, 32'h8000);
        if (dac_b !== 16'h8000)
            report_mismatch("dac_b", dac_b, 32'h8000);
        @(posedge adc_clk);
        reset <= 1'b0;                              // two edges under reset

        // counter pattern, spacing and up/down steps
        cps = 2 + random_bits(3);
        num = 3 + random_bits(5) % 18;
        @(posedge adc_clk);
        capture_cfg <= '{clocks_per_sample: interval_t'(cps),
                         num_samples: sample_count_t'(num), source: src_count};
        repeat (20) @(posedge adc_clk);             // new interval reloaded by now
        run_capture(num, 1'b0);
        for (int i = 1; i < got_q.size(); i++)
        begin
            if (got_cycle_q[i] - got_cycle_q[i-1] != cps + 1)
                report_mismatch("sample spacing", got_cycle_q[i] - got_cycle_q[i-1], cps + 1);
            if (got_q[i][31:16] !== got_q[i-1][31:16] + 16'd1)
                report_mismatch("capture_out.data up", got_q[i][31:16], got_q[i-1][31:16] + 16'd1);
            if (got_q[i][15:0] !== got_q[i-1][15:0] - 16'd1)
                report_mismatch("capture_out.data down", got_q[i][15:0], got_q[i-1][15:0] - 16'd1);
        end

        // converter a then converter b with random traffic
        for (int s = 0; s < 2; s++)
        begin
            num = 3 + random_bits(5) % 18;
            @(posedge adc_clk);
            capture_cfg.source      <= (s == 0) ? src_adc_a : src_adc_b;
            capture_cfg.num_samples <= sample_count_t'(num);
            run_capture(num, 1'b1);
            for (int i = 0; i < got_q.size(); i++)
                if (got_q[i] !== expect_q[i])
                    report_mismatch("capture_out.data", got_q[i], expect_q[i]);
        end

        // marker word
        num = 3 + random_bits(5) % 18;
        @(posedge adc_clk);
        capture_cfg.source      <= src_marker;
        capture_cfg.num_samples <= sample_count_t'(num);
        run_capture(num, 1'b0);
        foreach (got_q[i])
            if (got_q[i] !== MARKER_WORD)
                report_mismatch("capture_out.data", got_q[i], MARKER_WORD);

        // constant dac codes, two cycles after each change
        for (int code = 1; code < 4; code++)
        begin
            @(posedge adc_clk);
            dac_cfg.dac_a_sel <= dac_a_sel_e'(code);
            dac_cfg.dac_b_sel <= dac_b_sel_e'(code);
            repeat (2) @(posedge adc_clk);
            @(negedge adc_clk);
            if (dac_a !== const_code(1'b0, code))
                report_mismatch("dac_a", dac_a, const_code(1'b0, code));
            if (dac_b !== const_code(1'b1, code))
                report_mismatch("dac_b", dac_b, const_code(1'b1, code));
        end

        // loopback follows adc_a upper half with two cycles of delay
        @(posedge adc_clk);
        dac_cfg.dac_a_sel <= a_adc_loop;
        for (int k = 0; k < 12; k++)
        begin
            if (k != 0)
                @(posedge adc_clk);
            rnd = random_bits(32);
            adc_a <= '{data: rnd, valid: 1'b0};
            a_hist.push_back(rnd[31:16]);
            @(negedge adc_clk);
            if (k >= 2 && dac_a !== (a_hist[k-2] ^ 16'h8000))
                report_mismatch("dac_a", dac_a, a_hist[k-2] ^ 16'h8000);
        end

        // table fill, distinct by the low byte
        @(posedge adc_clk);
        dac_cfg <= '{dac_a_sel: a_mid, dac_b_sel: b_mid, lut_addr_sel: addr_counter,
                     run_once: 1'b0};
        for (int i = 0; i < 256; i++)
        begin
            @(posedge adc_clk);
            rnd          = random_bits(8);
            lut_model[i] = {rnd[7:0], i[7:0]};
            lut_wr <= '{en: 1'b1, addr: 16'(i), data: lut_model[i]};
        end
        @(posedge adc_clk);
        lut_wr  <= '0;
        dac_cfg <= '{dac_a_sel: a_mid, dac_b_sel: b_lut, lut_addr_sel: addr_counter,
                     run_once: 1'b1};
        repeat (300) @(posedge adc_clk);            // counter parks on the last entry
        @(negedge adc_clk);
        if (dac_b !== (lut_model[255] ^ 16'h8000))
            report_mismatch("dac_b", dac_b, lut_model[255] ^ 16'h8000);
        @(posedge adc_clk);
        lut_trig <= 1'b1;
        for (wait_cnt = 0; wait_cnt < 20; wait_cnt++)
        begin
            @(negedge adc_clk);
            if (dac_b === (lut_model[0] ^ 16'h8000))
                break;                              // playback reached entry 0
        end
        if (wait_cnt == 20)
            report_failure("table playback did not start within 20 cycles of lut_trig");
        else
        begin
            for (int i = 1; i < 264; i++)
            begin
                @(negedge adc_clk);
                if (dac_b !== (lut_model[i > 255 ? 255 : i] ^ 16'h8000))
                    report_mismatch("dac_b", dac_b, lut_model[i > 255 ? 255 : i] ^ 16'h8000);
            end
        end
        @(posedge adc_clk);
        lut_trig <= 1'b0;

        $display("errors: %0d, failures: %0d", error_count, fail_count);
        if (error_count == 0 && fail_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- scope_dac.f
verilog/scope_pkg.sv
verilog/dac_pkg.sv
verilog/sample_rate_gen.sv
verilog/capture_stream.sv
verilog/waveform_lut.sv
verilog/dac_output.sv
verilog/scope_dac_top.sv
bench/scope_dac_tb.sv

//--- verilog/capture_stream.sv
`timescale 1ns/1ps

module capture_stream
(
    input  logic                     adc_clk,
    input  logic                     reset,
    input  logic                     sample_go,     // strobe from rate generator
    input  scope_pkg::stream_word_t  adc_a,         // converter a word + valid
    input  scope_pkg::stream_word_t  adc_b,         // converter b word + valid
    input  scope_pkg::capture_cfg_t  cfg,
    input  logic                     start,         // capture request level
    output scope_pkg::stream_word_t  capture_out,   // words inside the window
    output scope_pkg::sample_count_t capture_count, // words passed so far
    output logic                     capture_busy   // window armed
);

    import scope_pkg::*;

    count16_t     count_up;                         // test pattern, upper half
    count16_t     count_down;                       // test pattern, lower half
    stream_word_t pattern_word;
    stream_word_t marker_word;
    stream_word_t mux_word;                         // selector input side
    sample_t      sel_data;                         // registered selector data
    logic         sel_valid;                        // registered selector valid
    logic         start_d;                          // start one cycle back
    logic         start_rise;
    logic         window_open;                      // busy and count not reached

    // free-running test counters, step on each sample strobe
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            count_up   <= '0;
            count_down <= '0;
        end
        else if (sample_go)
        begin
            count_up   <= count_up + 1'b1;
            count_down <= count_down - 1'b1;
        end
    end

    assign pattern_word = '{data: {count_up, count_down}, valid: sample_go};
    assign marker_word  = '{data: MARKER_WORD, valid: sample_go}; // paced like the pattern

    // 4-way stream selector
    always_comb
    begin
        case (cfg.source)
            src_adc_a: mux_word = adc_a;
            src_adc_b: mux_word = adc_b;
            src_count: mux_word = pattern_word;
            default:   mux_word = marker_word;
        endcase
    end

    always_ff @(posedge adc_clk)
    begin
        sel_data <= mux_word.data;                  // payload, no reset
    end

    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            sel_valid <= 1'b0;
        end
        else
        begin
            sel_valid <= mux_word.valid;
        end
    end

    assign start_rise  = start & ~start_d;
    assign window_open = capture_busy && (capture_count != cfg.num_samples);

    // window passes exactly num_samples valid words per start edge
    assign capture_out = '{data: sel_data, valid: sel_valid & window_open};

    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            start_d       <= 1'b0;
            capture_busy  <= 1'b0;
            capture_count <= '0;
        end
        else
        begin
            start_d <= start;
            if (start_rise)
            begin
                capture_busy  <= 1'b1;              // rearm, also restarts a running window
                capture_count <= '0;
            end
            else if (capture_busy && !window_open)
            begin
                capture_busy  <= 1'b0;              // count reached, close window
            end
            else if (capture_out.valid)
            begin
                capture_count <= capture_count + 1'b1;
            end
        end
    end

endmodule

//--- verilog/dac_output.sv
`timescale 1ns/1ps

module dac_output
(
    input  logic                    adc_clk,
    input  logic                    reset,
    input  dac_pkg::dac_cfg_t       cfg,
    input  scope_pkg::stream_word_t adc_a,       // converter a, loopback source
    input  dac_pkg::dac_word_t      lut_out,     // waveform table output
    output dac_pkg::dac_word_t      dac_a_word,  // registered a selector, signed
    output logic [15:0]             dac_a,       // offset binary to dac a
    output logic [15:0]             dac_b        // offset binary to dac b
);

    import dac_pkg::*;

    dac_word_t dac_b_word;                       // registered b selector, signed
    dac_word_t a_mux;
    dac_word_t b_mux;

    // source selectors
    always_comb
    begin
        case (cfg.dac_a_sel)
            a_adc_loop:      a_mux = adc_a.data[31:16];   // msb half of converter word
            a_plus_quarter:  a_mux = PLUS_QUARTER;
            a_minus_quarter: a_mux = MINUS_QUARTER;
            default:         a_mux = '0;
        endcase
        case (cfg.dac_b_sel)
            b_lut:           b_mux = lut_out;
            b_minus_quarter: b_mux = MINUS_QUARTER;
            b_plus_quarter:  b_mux = PLUS_QUARTER;
            default:         b_mux = '0;
        endcase
    end

    // selector stage then offset binary stage, two cycles end to end
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            dac_a_word <= '0;
            dac_b_word <= '0;
            dac_a      <= 16'h8000;              // mid-scale
            dac_b      <= 16'h8000;
        end
        else
        begin
            dac_a_word <= a_mux;
            dac_b_word <= b_mux;
            dac_a      <= {~dac_a_word[15], dac_a_word[14:0]};  // flip sign bit
            dac_b      <= {~dac_b_word[15], dac_b_word[14:0]};
        end
    end

endmodule

//--- verilog/dac_pkg.sv
package dac_pkg;

    typedef logic signed [15:0] dac_word_t; // two's complement dac sample

    // dac a source codes
    typedef enum logic [1:0] {
        a_adc_loop      = 2'd0,             // upper half of converter a word
        a_plus_quarter  = 2'd1,             // +1/4 full scale
        a_minus_quarter = 2'd2,             // -1/4 full scale
        a_mid           = 2'd3              // zero, mid-scale after conversion
    } dac_a_sel_e;

    // dac b source codes
    typedef enum logic [1:0] {
        b_lut           = 2'd0,             // waveform table output
        b_minus_quarter = 2'd1,
        b_plus_quarter  = 2'd2,
        b_mid           = 2'd3
    } dac_b_sel_e;

    // table read address source
    typedef enum logic {
        addr_counter = 1'b0,                // pattern / pulse playback
        addr_dac_a   = 1'b1                 // distortion correction lookup
    } lut_addr_sel_e;

    typedef struct packed {
        dac_a_sel_e    dac_a_sel;
        dac_b_sel_e    dac_b_sel;
        lut_addr_sel_e lut_addr_sel;
        logic          run_once;            // play table once per trigger
    } dac_cfg_t;

    localparam dac_word_t PLUS_QUARTER  = 16'h4000;
    localparam dac_word_t MINUS_QUARTER = 16'hC000;

    // table write port, low address bits only are decoded
    typedef struct packed {
        logic        en;                    // write strobe
        logic [15:0] addr;                  // table index
        dac_word_t   data;                  // entry value
    } lut_wr_t;

endpackage

//--- verilog/sample_rate_gen.sv
`timescale 1ns/1ps

module sample_rate_gen
(
    input  logic                 adc_clk,
    input  logic                 reset,
    input  scope_pkg::interval_t clocks_per_sample, // strobe period minus one
    output logic                 sample_go          // one-cycle sample strobe
);

    import scope_pkg::*;

    interval_t counter;                             // clocks left until next strobe

    // reload down-counter, strobe fires on the reload cycle
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            counter   <= clocks_per_sample;         // first strobe after a full period
            sample_go <= 1'b0;
        end
        else
        begin
            if (counter == '0)
            begin
                counter   <= clocks_per_sample;     // new interval picked up here
                sample_go <= 1'b1;
            end
            else
            begin
                counter   <= counter - 1'b1;
                sample_go <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/scope_dac_top.sv
`timescale 1ns/1ps

module scope_dac_top
#(
    parameter int LUT_ADDR_W = 8                       // waveform table address width
)
(
    input  logic                     adc_clk,
    input  logic                     reset,
    input  scope_pkg::stream_word_t  adc_a,            // converter a, parallel with valid
    input  scope_pkg::stream_word_t  adc_b,            // converter b, parallel with valid
    input  scope_pkg::capture_cfg_t  capture_cfg,
    input  logic                     start,            // capture request level
    output scope_pkg::stream_word_t  capture_out,
    output scope_pkg::sample_count_t capture_count,
    output logic                     capture_busy,
    input  dac_pkg::dac_cfg_t        dac_cfg,
    input  dac_pkg::lut_wr_t         lut_wr,           // table write port
    input  logic                     lut_trig,         // playback trigger level
    output logic [15:0]              dac_a,            // offset binary
    output logic [15:0]              dac_b
);

    import dac_pkg::*;

    logic      sample_go;                              // sample strobe
    dac_word_t dac_a_word;                             // dac a word into the table address
    dac_word_t lut_out;                                // table data into dac b selector

    sample_rate_gen sample_rate_gen_i
    (
        .adc_clk           (adc_clk),
        .reset             (reset),
        .clocks_per_sample (capture_cfg.clocks_per_sample),
        .sample_go         (sample_go)
    );

    capture_stream capture_stream_i
    (
        .adc_clk       (adc_clk),
        .reset         (reset),
        .sample_go     (sample_go),
        .adc_a         (adc_a),
        .adc_b         (adc_b),
        .cfg           (capture_cfg),
        .start         (start),
        .capture_out   (capture_out),
        .capture_count (capture_count),
        .capture_busy  (capture_busy)
    );

    waveform_lut #(
        .LUT_ADDR_W (LUT_ADDR_W)
    ) waveform_lut_i
    (
        .adc_clk    (adc_clk),
        .reset      (reset),
        .cfg        (dac_cfg),
        .lut_trig   (lut_trig),
        .dac_a_word (dac_a_word),
        .lut_wr     (lut_wr),
        .lut_out    (lut_out)
    );

    dac_output dac_output_i
    (
        .adc_clk    (adc_clk),
        .reset      (reset),
        .cfg        (dac_cfg),
        .adc_a      (adc_a),                           // loopback source for dac a
        .lut_out    (lut_out),
        .dac_a_word (dac_a_word),
        .dac_a      (dac_a),
        .dac_b      (dac_b)
    );

endmodule

//--- verilog/scope_pkg.sv
package scope_pkg;

    typedef logic [31:0] sample_t;          // converter or stream data word
    typedef logic [15:0] count16_t;         // test counter value
    typedef logic [29:0] sample_count_t;    // number of captured words
    typedef logic [23:0] interval_t;        // clocks between samples, minus one

    // data word with its valid strobe, valid kept at the lsb side
    typedef struct packed {
        sample_t data;                      // payload
        logic    valid;                     // one-cycle qualifier
    } stream_word_t;

    // capture source codes
    typedef enum logic [1:0] {
        src_adc_a  = 2'd0,                  // converter a
        src_adc_b  = 2'd1,                  // converter b
        src_count  = 2'd2,                  // up/down counter test pattern
        src_marker = 2'd3                   // fixed marker word
    } stream_sel_e;

    // acquisition control, held static by the host between captures
    typedef struct packed {
        interval_t     clocks_per_sample;   // sample strobe interval minus one
        sample_count_t num_samples;         // words per capture window
        stream_sel_e   source;              // which stream to capture
    } capture_cfg_t;

    localparam sample_t MARKER_WORD = 32'hDEADBEEF; // easy to spot in a dump

endpackage

//--- verilog/waveform_lut.sv
`timescale 1ns/1ps

module waveform_lut
#(
    parameter int LUT_ADDR_W = 8                        // table depth is 2**LUT_ADDR_W
)
(
    input  logic               adc_clk,
    input  logic               reset,
    input  dac_pkg::dac_cfg_t  cfg,
    input  logic               lut_trig,                // async playback trigger level
    input  dac_pkg::dac_word_t dac_a_word,              // registered dac a selector output
    input  dac_pkg::lut_wr_t   lut_wr,                  // host write port
    output dac_pkg::dac_word_t lut_out                  // registered table read data
);

    import dac_pkg::*;

    localparam logic [LUT_ADDR_W-1:0] ADDR_MAX = '1;    // last table entry

    logic [1:0]            trig_sync;                   // two-flop synchronizer
    logic                  trig_d;                      // edge register
    logic                  trig_pulse;
    logic [LUT_ADDR_W-1:0] addr_cnt;                    // playback address
    logic [LUT_ADDR_W-1:0] rd_addr;                     // registered read address
    dac_word_t             table_mem [2**LUT_ADDR_W];

    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            trig_sync <= '0;
            trig_d    <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[0], lut_trig};
            trig_d    <= trig_sync[1];
        end
    end

    assign trig_pulse = trig_sync[1] & ~trig_d;         // rising edge only

    // runs freely unless run_once holds it at the last entry
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            addr_cnt <= '0;
        end
        else if ((addr_cnt != ADDR_MAX) || !cfg.run_once || trig_pulse)
        begin
            addr_cnt <= addr_cnt + 1'b1;                // wraps max -> 0
        end
    end

    // read address source, dac a word uses its top bits as the index
    always_ff @(posedge adc_clk or posedge reset)
    begin
        if (reset)
        begin
            rd_addr <= '0;
        end
        else if (cfg.lut_addr_sel == addr_dac_a)
        begin
            rd_addr <= dac_a_word[15 -: LUT_ADDR_W];
        end
        else
        begin
            rd_addr <= addr_cnt;
        end
    end

    // table memory, sync write and registered read
    always_ff @(posedge adc_clk)
    begin
        if (lut_wr.en)
        begin
            table_mem[lut_wr.addr[LUT_ADDR_W-1:0]] <= lut_wr.data;
        end
        lut_out <= table_mem[rd_addr];                  // old data on same-address write
    end

endmodule
